// ==== bench/tb_counter_display.sv ====
module tb_counter_display;
  import ctrl_pkg::*;
  import display_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 200;                              // Per wait for hex_valid
  localparam int SETTLE_CYCLES  = NUM_DIGITS * (COUNT_WIDTH + 3) + 8;  // Longest conversion

  logic                              clk;
  logic                              reset;
  logic [BUTTON_COUNT-1:0]           buttons;                       // Active low
  logic [COUNT_WIDTH-1:0]            count;
  seg_t [NUM_DIGITS-1:0]             hex;
  logic                              hex_valid;

  logic [COUNT_WIDTH-1:0] model_count;   // Reference count
  logic [COUNT_WIDTH-1:0] count_prev;
  int                     stable_cycles; // Edges since count last moved
  logic                   settled;
  integer                 seed = 32'h13c;
  int                     error_count;
  int                     check_total;
  int                     test_count;

  counter_display_top u_counter_display_top (
    .clk       (clk),
    .reset     (reset),
    .buttons   (buttons),
    .count     (count),
    .hex       (hex),
    .hex_valid (hex_valid)
  );

  // --------------------
  // Clock and display model
  // --------------------

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Standard layout, a on bit 0 going clockwise, g on bit 6, active high
  function automatic seg_t segments_for(input int digit);
    case (digit)
      0:       return 7'b0111111;
      1:       return 7'b0000110;
      2:       return 7'b1011011;
      3:       return 7'b1001111;
      4:       return 7'b1100110;
      5:       return 7'b1101101;
      6:       return 7'b1111101;
      7:       return 7'b0000111;
      8:       return 7'b1111111;
      9:       return 7'b1101111;
      default: return 7'b0000000;
    endcase
  endfunction

  // Whole display for a value, least significant digit in hex[0]
  function automatic logic [7*NUM_DIGITS-1:0] expected_hex(input logic [COUNT_WIDTH-1:0] value);
    logic [7*NUM_DIGITS-1:0] result;
    int                      digit;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      digit             = (int'(value) / (BASE ** i)) % BASE;
      result[7*i +: 7]  = ~segments_for(digit);  // Display is active low
    end
    return result;
  endfunction

  // Count stability tracker
  always @(posedge clk) begin
    if (reset) begin
      count_prev    <= '0;
      stable_cycles <= 0;
    end else begin
      count_prev <= count;
      if (count != count_prev)             stable_cycles <= 0;
      else if (stable_cycles < SETTLE_CYCLES) stable_cycles <= stable_cycles + 1;
    end
  end

  assign settled = (stable_cycles >= SETTLE_CYCLES) && (count == count_prev);

  // Settled display must always show the decimal digits of count
  assert property (@(posedge clk) disable iff (reset)
    (hex_valid && settled) |-> (hex == expected_hex(count)))
  else begin
    error_count++;
    $display("error at time %0t: hex is %h, expected %h", $time, $sampled(hex),
             expected_hex($sampled(count)));
  end

  // --------------------
  // Helpers
  // --------------------

  // Wrap and clear rules, one button at a time
  task automatic update_model(input int idx);
    case (idx)
      BTN_INC:   model_count = model_count + COUNT_WIDTH'(1);
      BTN_DEC:   model_count = model_count - COUNT_WIDTH'(1);
      BTN_CLEAR: model_count = '0;
      default:   model_count = model_count;
    endcase
  endtask

  task automatic compare_count();
    check_total++;
    assert (count == model_count) else begin
      error_count++;
      $display("error at time %0t: count is %0d, expected %0d", $time, count, model_count);
    end
  endtask

  // Hold low for hold_cycles, check count 4 cycles in, then release 4+ cycles
  task automatic press_button(input int idx, input int hold_cycles);
    buttons[idx] = 1'b0;
    update_model(idx);
    for (int i = 1; (i <= 4) || (i <= hold_cycles); i++) begin
      @(negedge clk);
      if (i == hold_cycles) buttons[idx] = 1'b1;
      if (i == 4)           compare_count();
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic press_random(input int idx);
    press_button(idx, 3 + ($unsigned($random(seed)) % 6));  // 3 to 8 cycles low
  endtask

  // Wait for a settled, valid display and check it against the model
  task automatic wait_for_display();
    int cycles;
    cycles = 0;
    while (!(hex_valid && settled) && (cycles < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      error_count++;
      $display("timeout at time %0t: display never settled with hex_valid high", $time);
    end else begin
      check_total++;
      assert (hex == expected_hex(model_count)) else begin
        error_count++;
        $display("error at time %0t: hex is %h, expected %h", $time, hex,
                 expected_hex(model_count));
      end
      compare_count();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) $display("test %0d %s: ok", test_count, name);
    else $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
  endtask

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    int errors_before;
    reset       = 1'b1;
    buttons     = '1;                      // All released
    model_count = '0;
    error_count = 0;
    check_total = 0;
    test_count  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errors_before = error_count;           // Display of 0 after reset
    compare_count();
    wait_for_display();
    report_test("reset shows 000", errors_before);

    errors_before = error_count;
    for (int i = 0; i < 12; i++) press_random(BTN_INC);
    wait_for_display();
    report_test("twelve increments", errors_before);

    errors_before = error_count;           // 12 down to 0, then wrap
    for (int i = 0; i < 13; i++) press_random(BTN_DEC);
    wait_for_display();
    report_test("decrement wraps to 255", errors_before);

    errors_before = error_count;
    press_random(BTN_CLEAR);
    wait_for_display();
    report_test("clear", errors_before);

    errors_before = error_count;           // Presses faster than a conversion
    for (int i = 0; i < 20; i++) press_random($unsigned($random(seed)) % BUTTON_COUNT);
    wait_for_display();
    report_test("random burst", errors_before);

    errors_before = error_count;
    press_button(BTN_INC, 30);
    compare_count();                       // Still one step after release
    wait_for_display();
    report_test("long hold", errors_before);

    $display("%0d tests, %0d checks, %0d errors", test_count, check_total, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/ctrl_pkg.sv
hdl/display_pkg.sv
hdl/div_if.sv
hdl/button_sync.sv
hdl/up_down_counter.sv
hdl/nonrestoring_divider.sv
hdl/radix_converter.sv
hdl/seven_seg_decoder.sv
hdl/counter_display_top.sv
bench/tb_counter_display.sv

// ==== hdl/button_sync.sv ====
module button_sync #(
  parameter int BUTTON_COUNT = ctrl_pkg::BUTTON_COUNT
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [BUTTON_COUNT-1:0]   buttons,  // Active low, asynchronous
  output ctrl_pkg::counter_op_t     op
);
  import ctrl_pkg::*;

  logic [BUTTON_COUNT-1:0] sync_meta;   // First flop, may go metastable
  logic [BUTTON_COUNT-1:0] sync_level;  // Safe synchronized level
  logic [BUTTON_COUNT-1:0] level_prev;  // Level one cycle ago
  logic [BUTTON_COUNT-1:0] press;       // One-cycle pulse on 1 -> 0

  // Released buttons read as 1, so reset to released
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_meta  <= '1;
      sync_level <= '1;
      level_prev <= '1;
    end else begin
      sync_meta  <= buttons;
      sync_level <= sync_meta;
      level_prev <= sync_level;
    end
  end

  assign press = level_prev & ~sync_level;

  // Priority when presses coincide: clear, inc, dec
  always_comb begin
    if (press[BTN_CLEAR])    op = op_clear;
    else if (press[BTN_INC]) op = op_inc;
    else if (press[BTN_DEC]) op = op_dec;
    else                     op = op_none;
  end

  // A held button gives a single opcode, never a repeat on the next cycle
  assert property (@(posedge clk) disable iff (reset)
    (op != op_none) |=> (op != $past(op)));

endmodule

// ==== hdl/counter_display_top.sv ====
module counter_display_top #(
  parameter int COUNT_WIDTH = ctrl_pkg::COUNT_WIDTH,
  parameter int NUM_DIGITS  = display_pkg::NUM_DIGITS,
  parameter int BASE        = display_pkg::BASE
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [ctrl_pkg::BUTTON_COUNT-1:0]   buttons,    // Active low
  output logic [COUNT_WIDTH-1:0]              count,
  output display_pkg::seg_t [NUM_DIGITS-1:0]  hex,
  output logic                                hex_valid
);
  import ctrl_pkg::*;
  import display_pkg::*;

  counter_op_t                            op;
  logic [COUNT_WIDTH-1:0]                 num;
  logic                                   num_valid;
  logic                                   num_ready;
  logic [NUM_DIGITS-1:0][DIGIT_WIDTH-1:0] digits;
  logic                                   digits_valid;

  div_if #(.WIDTH(COUNT_WIDTH)) div_bus ();

  // --------------------
  // Buttons to counter
  // --------------------

  button_sync #(.BUTTON_COUNT(BUTTON_COUNT)) u_button_sync (
    .clk     (clk),
    .reset   (reset),
    .buttons (buttons),
    .op      (op)
  );

  up_down_counter #(.COUNT_WIDTH(COUNT_WIDTH)) u_counter (
    .clk       (clk),
    .reset     (reset),
    .op        (op),
    .count     (count),
    .num       (num),
    .num_valid (num_valid),
    .num_ready (num_ready)
  );

  // --------------------
  // Conversion and display
  // --------------------

  radix_converter #(.WIDTH(COUNT_WIDTH), .NUM_DIGITS(NUM_DIGITS)) u_converter (
    .clk          (clk),
    .reset        (reset),
    .num          (num),
    .num_valid    (num_valid),
    .num_ready    (num_ready),
    .div          (div_bus.master),
    .digits       (digits),
    .digits_valid (digits_valid)
  );

  nonrestoring_divider #(.WIDTH(COUNT_WIDTH), .BASE(BASE)) u_divider (
    .clk   (clk),
    .reset (reset),
    .div   (div_bus.slave)
  );

  seven_seg_decoder #(.NUM_DIGITS(NUM_DIGITS)) u_decoder (
    .clk          (clk),
    .reset        (reset),
    .digits       (digits),
    .digits_valid (digits_valid),
    .hex          (hex),
    .hex_valid    (hex_valid)
  );

endmodule

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

  // --------------------
  // Counter sizing
  // --------------------

  localparam int COUNT_WIDTH = 8;   // Counter and number width, default for the top level

  // --------------------
  // Buttons
  // --------------------

  localparam int BUTTON_COUNT = 3;  // Increment, decrement, clear

  // Bit positions inside the buttons bus
  localparam int BTN_INC   = 0;
  localparam int BTN_DEC   = 1;
  localparam int BTN_CLEAR = 2;

  // One operation per cycle from the button block to the counter
  typedef enum logic [1:0] {
    op_none,   // Nothing pressed this cycle
    op_inc,    // Count up, wraps at the top
    op_dec,    // Count down, wraps at zero
    op_clear   // Back to zero
  } counter_op_t;

endpackage

// ==== hdl/display_pkg.sv ====
package display_pkg;

  // --------------------
  // Number conversion
  // --------------------

  localparam int NUM_DIGITS  = 3;   // Enough for 0..255
  localparam int BASE        = 10;  // Decimal display
  localparam int DIGIT_WIDTH = 4;   // One hex nibble per digit

  // --------------------
  // Segment pattern
  // --------------------

  // Active low, one bit per segment
  //      0
  //    5   1
  //      6
  //    4   2
  //      3
  typedef logic [6:0] seg_t;

  // --------------------
  // Converter FSM
  // --------------------

  typedef enum logic [1:0] {
    conv_idle,   // Ready for a new number
    conv_start,  // Raise start for the next digit
    conv_wait,   // Divider busy
    conv_done    // All digits stored
  } conv_state_t;

endpackage

// ==== hdl/div_if.sv ====
interface div_if #(
  parameter int WIDTH = ctrl_pkg::COUNT_WIDTH
) ();

  logic             start;      // Held high for the whole division
  logic             done;       // High until start falls
  logic [WIDTH-1:0] dividend;   // Must stay stable while start is high
  logic [WIDTH-1:0] quotient;
  logic [WIDTH-1:0] remainder;

  // Converter side
  modport master (
    output start, dividend,
    input  done, quotient, remainder
  );

  // Divider side
  modport slave (
    input  start, dividend,
    output done, quotient, remainder
  );

endinterface

// ==== hdl/nonrestoring_divider.sv ====
module nonrestoring_divider #(
  parameter int WIDTH = ctrl_pkg::COUNT_WIDTH,
  parameter int BASE  = display_pkg::BASE
) (
  input logic  clk,
  input logic  reset,
  div_if.slave div
);

  localparam logic [WIDTH-1:0] DIVISOR = WIDTH'(BASE);
  localparam int STEP_W = $clog2(WIDTH + 1);

  logic [2*WIDTH-1:0] acc;            // Partial remainder : remaining dividend bits
  logic [WIDTH-1:0]   quotient_reg;
  logic [STEP_W-1:0]  steps_left;     // 0 means idle or finished
  logic               load;
  logic               last_step;

  logic [2*WIDTH-1:0] acc_shifted;
  logic [WIDTH-1:0]   rem_shifted;
  logic [WIDTH-1:0]   rem_step;       // Signed partial remainder after add/sub
  logic [WIDTH-1:0]   rem_final;      // Corrected back to non-negative

  // --------------------
  // One step of the recurrence
  // --------------------

  assign acc_shifted = acc << 1;
  assign rem_shifted = acc_shifted[2*WIDTH-1:WIDTH];

  // Negative partial remainder adds the divisor back, otherwise subtract
  assign rem_step  = rem_shifted[WIDTH-1] ? rem_shifted + DIVISOR : rem_shifted - DIVISOR;
  assign rem_final = rem_step[WIDTH-1] ? rem_step + DIVISOR : rem_step;

  assign load      = div.start && !div.done && (steps_left == '0);
  assign last_step = (steps_left == STEP_W'(1));

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      steps_left <= '0;
      div.done   <= 1'b0;
    end else if (div.start) begin
      if (load) begin
        steps_left <= STEP_W'(WIDTH);            // WIDTH steps follow the load
      end else if (!div.done) begin
        steps_left <= steps_left - STEP_W'(1);
        if (last_step) div.done <= 1'b1;         // Held until start drops
      end
    end else begin
      div.done <= 1'b0;                          // Handshake closes
    end
  end

  // --------------------
  // Datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (load) begin
      acc <= {{WIDTH{1'b0}}, div.dividend};
    end else if (div.start && !div.done) begin
      acc          <= {last_step ? rem_final : rem_step, acc_shifted[WIDTH-1:0]};
      quotient_reg <= {quotient_reg[WIDTH-2:0], ~rem_step[WIDTH-1]};  // 1 if non-negative
    end
  end

  assign div.quotient  = quotient_reg;
  assign div.remainder = acc[2*WIDTH-1:WIDTH];

  // Signed partial remainder spans -2*BASE..2*BASE-1 and must fit in WIDTH bits
  assert property (@(posedge clk) disable iff (reset)
    (BASE > 0) && (BASE <= 2 ** (WIDTH - 2)));

  // Master keeps the dividend steady for a running division
  assert property (@(posedge clk) disable iff (reset)
    (div.start && $past(div.start)) |-> $stable(div.dividend));

endmodule

// ==== hdl/radix_converter.sv ====
module radix_converter #(
  parameter int WIDTH      = ctrl_pkg::COUNT_WIDTH,
  parameter int NUM_DIGITS = display_pkg::NUM_DIGITS
) (
  input  logic                                             clk,
  input  logic                                             reset,
  input  logic [WIDTH-1:0]                                 num,
  input  logic                                             num_valid,
  output logic                                             num_ready,
  div_if.master                                            div,
  output logic [NUM_DIGITS-1:0][display_pkg::DIGIT_WIDTH-1:0] digits,
  output logic                                             digits_valid
);
  import display_pkg::*;

  localparam int IDX_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;

  conv_state_t      state;
  logic [WIDTH-1:0] work;         // Number still to be split
  logic [IDX_W-1:0] idx;          // Digit position, LSD first
  logic             accept;
  logic             digit_done;
  logic             last_digit;

  assign num_ready    = (state == conv_idle);
  assign accept       = num_ready && num_valid;
  assign digit_done   = (state == conv_wait) && div.done;
  assign last_digit   = (idx == IDX_W'(NUM_DIGITS - 1));
  assign div.dividend = work;     // Only changes while start is low

  // --------------------
  // FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= conv_idle;
      div.start    <= 1'b0;
      idx          <= '0;
      digits_valid <= 1'b0;
    end else begin
      case (state)
        conv_idle: begin
          if (num_valid) begin
            idx          <= '0;
            digits_valid <= 1'b0;          // Old digits go stale
            state        <= conv_start;
          end
        end
        conv_start: begin
          div.start <= 1'b1;
          state     <= conv_wait;
        end
        conv_wait: begin
          if (div.done) begin
            div.start <= 1'b0;             // Low for one cycle between digits
            if (last_digit) begin
              state <= conv_done;
            end else begin
              idx   <= idx + IDX_W'(1);
              state <= conv_start;
            end
          end
        end
        conv_done: begin
          digits_valid <= 1'b1;
          state        <= conv_idle;
        end
        default: state <= conv_idle;
      endcase
    end
  end

  // --------------------
  // Working number and digit store
  // --------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      work <= num;
    end else if (digit_done) begin
      digits[idx] <= div.remainder[DIGIT_WIDTH-1:0];  // Remainder < BASE
      work        <= div.quotient;                    // Next digit works on the quotient
    end
  end

endmodule

// ==== hdl/seven_seg_decoder.sv ====
module seven_seg_decoder #(
  parameter int NUM_DIGITS = display_pkg::NUM_DIGITS
) (
  input  logic                                             clk,
  input  logic                                             reset,
  input  logic [NUM_DIGITS-1:0][display_pkg::DIGIT_WIDTH-1:0] digits,
  input  logic                                             digits_valid,
  output display_pkg::seg_t [NUM_DIGITS-1:0]               hex,
  output logic                                             hex_valid
);
  import display_pkg::*;

  // Active-high patterns, bit 6 is the middle bar
  localparam seg_t SEG_TABLE [16] = '{
    7'b0111111,  // 0
    7'b0000110,  // 1
    7'b1011011,  // 2
    7'b1001111,  // 3
    7'b1100110,  // 4
    7'b1101101,  // 5
    7'b1111101,  // 6
    7'b0000111,  // 7
    7'b1111111,  // 8
    7'b1101111,  // 9
    7'b1110111,  // A
    7'b1111100,  // b
    7'b0111001,  // C
    7'b1011110,  // d
    7'b1111001,  // E
    7'b1110001   // F
  };

  // One register stage, inverted for the active-low display
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_DIGITS; i++) begin
      hex[i] <= ~SEG_TABLE[digits[i]];
    end
  end

  // Valid follows the same single stage
  always_ff @(posedge clk) begin
    if (reset) hex_valid <= 1'b0;
    else       hex_valid <= digits_valid;
  end

endmodule

// ==== hdl/up_down_counter.sv ====
module up_down_counter #(
  parameter int COUNT_WIDTH = ctrl_pkg::COUNT_WIDTH
) (
  input  logic                   clk,
  input  logic                   reset,
  input  ctrl_pkg::counter_op_t  op,
  output logic [COUNT_WIDTH-1:0] count,
  output logic [COUNT_WIDTH-1:0] num,        // Value offered to the converter
  output logic                   num_valid,
  input  logic                   num_ready
);
  import ctrl_pkg::*;

  logic [COUNT_WIDTH-1:0] count_next;
  logic                   changed;

  // Wraps both ways through plain modulo arithmetic
  always_comb begin
    case (op)
      op_inc:   count_next = count + COUNT_WIDTH'(1);
      op_dec:   count_next = count - COUNT_WIDTH'(1);
      op_clear: count_next = '0;
      default:  count_next = count;
    endcase
  end

  assign changed = (count_next != count);  // Clear at zero is no change

  // --------------------
  // Count and offer
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count     <= '0;
      num_valid <= 1'b1;                 // Show 0 right after reset
    end else begin
      count <= count_next;
      if (changed) begin
        num_valid <= 1'b1;               // New value wins over a transfer
      end else if (num_valid && num_ready) begin
        num_valid <= 1'b0;               // Taken by the converter
      end
    end
  end

  // Offered value tracks the newest count while valid waits
  assign num = count;

  // Count only moves one cycle after a real opcode
  assert property (@(posedge clk) disable iff (reset)
    !$stable(count) |-> ($past(op) != op_none));

endmodule
